//--- filelist.f
+incdir+design
design/aes_kv_pkg.sv
design/aes_edn_pkg.sv
design/aes_data_out_gate.sv
design/aes_kv_capture.sv
design/aes_edn_arbiter.sv
design/aes_kv_wrapper.sv
verification/aes_kv_wrapper_assertions.sv
verification/tb_aes_kv_wrapper.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the key-vault wrapper testbench
# Exits nonzero when the build or the run fails, or the log reports failure

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f filelist.f \
  --top-module tb_aes_kv_wrapper -o tb_aes_kv_wrapper
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_aes_kv_wrapper +verilator+error+limit+100 > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q -F '*** FAILED ***' "$LOG"; then
  exit 1
fi
exit 0

//--- verification/tb_aes_kv_wrapper.sv
////////////////////
// Testbench for the AES key-vault wrapper
// The core model answers a read-enable in the same cycle
////////////////////

`timescale 1ns/1ps
`include "aes_kv_macros.svh"

module tb_aes_kv_wrapper;
  import aes_kv_pkg::*;
  import aes_edn_pkg::*;

  localparam int unsigned SEED = 32'h7927b4c0;
  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 8;
  // The tests take under 200 cycles
  localparam int WATCHDOG_CYCLES = 2000;
  localparam int KV_TIMEOUT      = 20;

  logic                  clk_i;
  logic                  rst_ni;
  core_status_t          core_q;
  logic                  core_ov_q;
  core_status_t          core_status;
  logic                  data_out_re_o;
  logic                  sw_data_out_re_i;
  aes_block_t            data_out_o;
  logic                  data_in0_we_i;
  logic                  idle_o;
  logic                  kv_en_i;
  kv_out_t               kv_o;
  logic                  kv_write_done_i;
  logic                  clr_req_i;
  logic                  msk_req_i;
  logic                  clr_ack_o;
  logic                  msk_ack_o;
  logic [`AES_EDN_W-1:0] entropy_o;
  logic                  edn_req_o;
  edn_rsp_t              edn_rsp_i;
  int                    checks = 0;
  int                    errors = 0;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Core drops output_valid in the cycle it sees the read-enable
  always_comb begin
    core_status = core_q;
    if (core_ov_q && data_out_re_o) begin
      core_status.ov_we        = 1'b1;
      core_status.output_valid = 1'b0;
    end
  end

  aes_kv_wrapper u_aes_kv_wrapper (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .core_status_i    (core_status),
    .data_out_re_o    (data_out_re_o),
    .sw_data_out_re_i (sw_data_out_re_i),
    .data_out_o       (data_out_o),
    .data_in0_we_i    (data_in0_we_i),
    .idle_o           (idle_o),
    .kv_en_i          (kv_en_i),
    .kv_o             (kv_o),
    .kv_write_done_i  (kv_write_done_i),
    .clr_req_i        (clr_req_i),
    .msk_req_i        (msk_req_i),
    .clr_ack_o        (clr_ack_o),
    .msk_ack_o        (msk_ack_o),
    .entropy_o        (entropy_o),
    .edn_req_o        (edn_req_o),
    .edn_rsp_i        (edn_rsp_i)
  );

  bind aes_kv_wrapper aes_kv_wrapper_assertions u_assertions (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .kv_valid_i (kv_o.valid),
    .kv_state_i (u_kv_capture.state_q),
    .edn_req_i  (edn_req_o),
    .edn_ack_i  (edn_rsp_i.ack),
    .clr_ack_i  (clr_ack_o),
    .msk_ack_i  (msk_ack_o)
  );

  // Software sees nothing while the vault owns the output
  conceal_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    u_aes_kv_wrapper.intercept |->
      (data_out_o == '0) && (data_out_re_o == u_aes_kv_wrapper.output_valid_q))
  else begin
    errors++;
    $display("Fail concealment: expected data_out_o 0 re %b, actual data_out_o %h re %b",
             $sampled(u_aes_kv_wrapper.output_valid_q), $sampled(data_out_o),
             $sampled(data_out_re_o));
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_value(input string name, input logic [`AES_BLOCK_W-1:0] exp_val,
                             input logic [`AES_BLOCK_W-1:0] act_val);
    checks++;
    assert (act_val === exp_val) else begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, exp_val, act_val);
    end
  endtask

  function automatic aes_block_t random_block();
    aes_block_t blk;
    for (int w = 0; w < `AES_DATA_WORDS; w++) begin
      blk[w] = $urandom();
    end
    return blk;
  endfunction

  // Software writes input word 0 and the core leaves idle
  task automatic arm_capture(input logic kv_en);
    @(posedge clk_i);
    kv_en_i        <= kv_en;
    data_in0_we_i  <= 1'b1;
    core_q.idle_we <= 1'b1;
    core_q.idle    <= 1'b0;
    @(posedge clk_i);
    data_in0_we_i  <= 1'b0;
    core_q.idle_we <= 1'b0;
  endtask

  // Ends on the falling edge after output_valid_q has loaded
  task automatic issue_block(input aes_block_t blk);
    @(posedge clk_i);
    core_q.ov_we        <= 1'b1;
    core_q.output_valid <= 1'b1;
    core_q.data_out     <= blk;
    core_ov_q           <= 1'b1;
    @(posedge clk_i);
    core_q.ov_we <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic await_read();
    while (!data_out_re_o) @(negedge clk_i);
    @(posedge clk_i);
    core_ov_q <= 1'b0;
  endtask

  task automatic signal_idle();
    @(posedge clk_i);
    core_q.idle_we <= 1'b1;
    core_q.idle    <= 1'b1;
    @(posedge clk_i);
    core_q.idle_we <= 1'b0;
  endtask

  task automatic wait_kv_valid(input string name);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!kv_o.valid && cycles < KV_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    checks++;
    assert (kv_o.valid) else begin
      errors++;
      $display("%s: kv_o.valid did not rise within %0d cycles", name, KV_TIMEOUT);
    end
  endtask

  task automatic release_vault(input string name);
    @(posedge clk_i);
    kv_write_done_i <= 1'b1;
    @(posedge clk_i);
    kv_write_done_i <= 1'b0;
    @(negedge clk_i);
    check_value({name, " valid"}, '0, `AES_BLOCK_W'(kv_o.valid));
    for (int i = 0; i < `AES_KV_CHUNKS; i++) begin
      check_value($sformatf("%s chunk %0d", name, i), '0,
                  kv_o.data[i*`AES_BLOCK_W +: `AES_BLOCK_W]);
    end
  endtask

  ////////////////////
  // Tests
  ////////////////////

  initial begin
    int unsigned           seed_val;
    aes_block_t            blocks [6];
    aes_block_t            blk;
    logic [`AES_EDN_W-1:0] bus_val;
    int unsigned           assert_fails;
    seed_val         = $urandom(SEED);
    clk_i            = 1'b0;
    rst_ni           = 1'b0;
    core_q           = '0;
    core_ov_q        = 1'b0;
    sw_data_out_re_i = 1'b0;
    data_in0_we_i    = 1'b0;
    kv_en_i          = 1'b0;
    kv_write_done_i  = 1'b0;
    clr_req_i        = 1'b0;
    msk_req_i        = 1'b0;
    edn_rsp_i        = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_value("reset outputs", '0, `AES_BLOCK_W'({kv_o.valid, edn_req_o, idle_o,
                data_out_re_o, clr_ack_o, msk_ack_o}));

    // Four blocks into the vault buffer
    arm_capture(1'b1);
    for (int i = 0; i < `AES_KV_CHUNKS; i++) begin
      blocks[i] = random_block();
      issue_block(blocks[i]);
      check_value("conceal data_out_o", '0, data_out_o);
      check_value("conceal data_out_re_o", `AES_BLOCK_W'(1'b1), `AES_BLOCK_W'(data_out_re_o));
      await_read();
    end
    signal_idle();
    wait_kv_valid("capture");
    check_value("capture idle_o", `AES_BLOCK_W'(1'b1), `AES_BLOCK_W'(idle_o));
    for (int i = 0; i < `AES_KV_CHUNKS; i++) begin
      check_value($sformatf("capture chunk %0d", i), blocks[i],
                  kv_o.data[i*`AES_BLOCK_W +: `AES_BLOCK_W]);
    end
    release_vault("capture release");

    // Without a vault destination software owns the output
    arm_capture(1'b0);
    blk = random_block();
    issue_block(blk);
    check_value("bypass data_out_o", blk, data_out_o);
    check_value("bypass re low", '0, `AES_BLOCK_W'(data_out_re_o));
    @(posedge clk_i);
    sw_data_out_re_i <= 1'b1;
    @(negedge clk_i);
    check_value("bypass re high", `AES_BLOCK_W'(1'b1), `AES_BLOCK_W'(data_out_re_o));
    await_read();
    sw_data_out_re_i <= 1'b0;

    // Six blocks with the last one landing in chunk 3
    arm_capture(1'b1);
    for (int i = 0; i < 6; i++) begin
      blocks[i] = random_block();
      issue_block(blocks[i]);
      await_read();
    end
    signal_idle();
    wait_kv_valid("saturation");
    for (int i = 0; i < `AES_KV_CHUNKS - 1; i++) begin
      check_value($sformatf("saturation chunk %0d", i), blocks[i],
                  kv_o.data[i*`AES_BLOCK_W +: `AES_BLOCK_W]);
    end
    check_value("saturation chunk 3", blocks[5], kv_o.data[3*`AES_BLOCK_W +: `AES_BLOCK_W]);
    release_vault("saturation release");

    // Entropy priority
    bus_val = $urandom();
    @(posedge clk_i);
    clr_req_i     <= 1'b1;
    msk_req_i     <= 1'b1;
    edn_rsp_i.ack <= 1'b1;
    edn_rsp_i.bus <= bus_val;
    @(negedge clk_i);
    check_value("priority acks", `AES_BLOCK_W'(2'b10), `AES_BLOCK_W'({clr_ack_o, msk_ack_o}));
    check_value("priority entropy_o", `AES_BLOCK_W'(bus_val), `AES_BLOCK_W'(entropy_o));
    @(posedge clk_i);
    clr_req_i     <= 1'b0;
    msk_req_i     <= 1'b0;
    edn_rsp_i.ack <= 1'b0;

    // Entropy hold after the requester drops
    @(posedge clk_i);
    msk_req_i <= 1'b1;
    @(posedge clk_i);
    msk_req_i <= 1'b0;
    repeat (3) begin
      @(negedge clk_i);
      check_value("hold edn_req_o", `AES_BLOCK_W'(1'b1), `AES_BLOCK_W'(edn_req_o));
    end
    @(posedge clk_i);
    edn_rsp_i.ack <= 1'b1;
    @(negedge clk_i);
    check_value("hold edn_req_o at ack", `AES_BLOCK_W'(1'b1), `AES_BLOCK_W'(edn_req_o));
    @(posedge clk_i);
    edn_rsp_i.ack <= 1'b0;
    @(negedge clk_i);
    check_value("hold edn_req_o after ack", '0, `AES_BLOCK_W'(edn_req_o));

    repeat (2) @(posedge clk_i);
    assert_fails = u_aes_kv_wrapper.u_assertions.fail_cnt;
    $display("Checks: %0d, check errors: %0d, assertion failures: %0d",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- verification/aes_kv_wrapper_assertions.sv
////////////////////
// Protocol assertions bound into the key-vault wrapper
// fail_cnt holds the number of failed assertions
////////////////////

`timescale 1ns/1ps

module aes_kv_wrapper_assertions (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  kv_valid_i,
  input  aes_kv_pkg::kv_state_e kv_state_i,
  input  logic                  edn_req_i,
  input  logic                  edn_ack_i,
  input  logic                  clr_ack_i,
  input  logic                  msk_ack_i
);
  import aes_kv_pkg::*;

  int unsigned fail_cnt = 0;

  // Vault valid only while the FSM holds a completed buffer
  valid_in_kv_valid_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    kv_valid_i |-> (kv_state_i == KvValid))
  else begin
    fail_cnt++;
    $error("kv_o.valid is high while the capture FSM is in state %0d", kv_state_i);
  end

  // An unacknowledged entropy request stays up
  req_held_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (edn_req_i && !edn_ack_i) |=> edn_req_i)
  else begin
    fail_cnt++;
    $error("edn_req_o dropped before the entropy port acknowledged");
  end

  // One requester served at a time
  ack_onehot_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(clr_ack_i && msk_ack_i))
  else begin
    fail_cnt++;
    $error("clr_ack_o and msk_ack_o are high together");
  end

endmodule

//--- design/aes_kv_wrapper.sv
////////////////////
// AES wrapper, key-vault side
// The AES core sits outside; its status and data arrive on core_status_i
// Entropy shares clk_i and rst_ni with the rest of the wrapper
////////////////////

`timescale 1ns/1ps
`include "aes_kv_macros.svh"

module aes_kv_wrapper (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // AES core
  input  aes_kv_pkg::core_status_t core_status_i,
  output logic                     data_out_re_o,

  // Software access
  input  logic                     sw_data_out_re_i,
  output aes_kv_pkg::aes_block_t   data_out_o,
  input  logic                     data_in0_we_i,
  output logic                     idle_o,

  // Key vault
  input  logic                     kv_en_i,
  output aes_kv_pkg::kv_out_t      kv_o,
  input  logic                     kv_write_done_i,

  // Entropy requesters
  input  logic                     clr_req_i,
  input  logic                     msk_req_i,
  output logic                     clr_ack_o,
  output logic                     msk_ack_o,
  output logic [`AES_EDN_W-1:0]    entropy_o,

  // Entropy port
  output logic                     edn_req_o,
  input  aes_edn_pkg::edn_rsp_t    edn_rsp_i
);

  logic intercept;
  logic output_valid_q;

  ////////////////////
  // Output data path
  ////////////////////

  // idle_o doubles as the registered idle status for the capture block
  aes_data_out_gate u_data_out_gate (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .core_status_i    (core_status_i),
    .intercept_i      (intercept),
    .sw_data_out_re_i (sw_data_out_re_i),
    .data_out_o       (data_out_o),
    .data_out_re_o    (data_out_re_o),
    .output_valid_q_o (output_valid_q),
    .idle_q_o         (idle_o)
  );

  aes_kv_capture u_kv_capture (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .core_status_i    (core_status_i),
    .output_valid_q_i (output_valid_q),
    .idle_q_i         (idle_o),
    .data_in0_we_i    (data_in0_we_i),
    .kv_en_i          (kv_en_i),
    .kv_write_done_i  (kv_write_done_i),
    .intercept_o      (intercept),
    .kv_o             (kv_o)
  );

  ////////////////////
  // Entropy
  ////////////////////

  aes_edn_arbiter u_edn_arbiter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .clr_req_i (clr_req_i),
    .msk_req_i (msk_req_i),
    .edn_rsp_i (edn_rsp_i),
    .clr_ack_o (clr_ack_o),
    .msk_ack_o (msk_ack_o),
    .edn_req_o (edn_req_o),
    .entropy_o (entropy_o)
  );

endmodule

//--- design/aes_edn_arbiter.sv
////////////////////
// Fixed-priority arbiter of two PRNG reseed requests onto one entropy port
// A request dropped before its ack is held until the ack arrives
////////////////////

`timescale 1ns/1ps
`include "aes_kv_macros.svh"

module aes_edn_arbiter (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clr_req_i,
  input  logic                   msk_req_i,
  input  aes_edn_pkg::edn_rsp_t  edn_rsp_i,
  output logic                   clr_ack_o,
  output logic                   msk_ack_o,
  output logic                   edn_req_o,
  output logic [`AES_EDN_W-1:0]  entropy_o
);
  import aes_edn_pkg::*;

  edn_grant_e grant;
  logic       hold_q;

  // Clearing PRNG first
  always_comb begin
    if (clr_req_i) begin
      grant = GrantClearing;
    end else if (msk_req_i) begin
      grant = GrantMasking;
    end else begin
      grant = GrantNone;
    end
  end

  // Ack only reaches the requester being served
  assign clr_ack_o = edn_rsp_i.ack & (grant == GrantClearing);
  assign msk_ack_o = edn_rsp_i.ack & (grant == GrantMasking);

  assign edn_req_o = clr_req_i | msk_req_i | hold_q;

  // Keep the port requesting until it acknowledges
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_q <= 1'b0;
    end else begin
      hold_q <= edn_req_o & ~edn_rsp_i.ack;
    end
  end

  assign entropy_o = edn_rsp_i.bus;

endmodule

//--- design/aes_kv_capture.sv
////////////////////
// Key-vault capture of consecutive output blocks into one write buffer
// Arming is only accepted in the idle state
// Blocks past the last chunk overwrite the last chunk
// Completion needs an idle-set event with the counter saturated
////////////////////

`timescale 1ns/1ps
`include "aes_kv_macros.svh"

module aes_kv_capture (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  aes_kv_pkg::core_status_t core_status_i,
  input  logic                     output_valid_q_i,
  input  logic                     idle_q_i,
  input  logic                     data_in0_we_i,
  input  logic                     kv_en_i,
  input  logic                     kv_write_done_i,
  output logic                     intercept_o,
  output aes_kv_pkg::kv_out_t      kv_o
);
  import aes_kv_pkg::*;

  kv_state_e                state_q;
  kv_state_e                state_d;
  logic [`AES_KV_CNT_W-1:0] cnt_q;
  logic [`AES_KV_WR_DW-1:0] buf_q;
  logic                     valid_q;

  logic                     arm;
  logic                     capture;
  logic                     idle_set;
  logic                     cnt_last;
  logic                     complete;
  logic                     release_kv;

  ////////////////////
  // Events
  ////////////////////

  // Software writes the first input word with a vault destination selected
  assign arm        = (state_q == KvIdle) & data_in0_we_i & kv_en_i;
  assign capture    = (state_q == KvCapture) & output_valid_q_i;
  // Rising edge of the idle status, seen on its update strobe
  assign idle_set   = core_status_i.idle_we & core_status_i.idle & ~idle_q_i;
  assign cnt_last   = (cnt_q == `AES_KV_CNT_W'(`AES_KV_CHUNKS - 1));
  assign complete   = (state_q == KvCapture) & idle_set & cnt_last;
  assign release_kv = (state_q == KvValid) & kv_write_done_i;

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      KvIdle: begin
        if (arm) begin
          state_d = KvCapture;
        end
      end
      KvCapture: begin
        // Early idle-set keeps capturing
        if (complete) begin
          state_d = KvValid;
        end
      end
      KvValid: begin
        if (release_kv) begin
          state_d = KvIdle;
        end
      end
      default: state_d = KvIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= KvIdle;
    end else begin
      state_q <= state_d;
    end
  end

  assign intercept_o = (state_q == KvCapture);

  ////////////////////
  // Counter and buffer
  ////////////////////

  // Chunk index, saturates on the last chunk
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (release_kv) begin
      cnt_q <= '0;
    end else if (capture && !cnt_last) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Key material is wiped once the vault has taken it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buf_q <= '0;
    end else if (release_kv) begin
      buf_q <= '0;
    end else if (capture) begin
      buf_q[cnt_q*`AES_BLOCK_W +: `AES_BLOCK_W] <= core_status_i.data_out;
    end
  end

  // Valid level, set on completion and held until write-done
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (release_kv) begin
      valid_q <= 1'b0;
    end else if (complete) begin
      valid_q <= 1'b1;
    end
  end

  assign kv_o.valid = valid_q;
  assign kv_o.data  = buf_q;

endmodule

//--- design/aes_data_out_gate.sv
////////////////////
// Idle and output-valid status registers with data-out concealment
// While intercepting, software reads zero and the core read-enable
// follows the registered output-valid flag
////////////////////

`timescale 1ns/1ps
`include "aes_kv_macros.svh"

module aes_data_out_gate (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  aes_kv_pkg::core_status_t core_status_i,
  input  logic                     intercept_i,
  input  logic                     sw_data_out_re_i,
  output aes_kv_pkg::aes_block_t   data_out_o,
  output logic                     data_out_re_o,
  output logic                     output_valid_q_o,
  output logic                     idle_q_o
);
  import aes_kv_pkg::*;

  logic       output_valid_q;
  logic       idle_q;
  aes_block_t conceal_mask;

  ////////////////////
  // Status registers
  ////////////////////

  // Output valid, updated on the core's write strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      output_valid_q <= 1'b0;
    end else if (core_status_i.ov_we) begin
      output_valid_q <= core_status_i.output_valid;
    end
  end

  // Idle, updated on the core's write strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idle_q <= 1'b0;
    end else if (core_status_i.idle_we) begin
      idle_q <= core_status_i.idle;
    end
  end

  assign output_valid_q_o = output_valid_q;
  assign idle_q_o         = idle_q;

  ////////////////////
  // Concealment
  ////////////////////

  // All ones while software may read, all zeros while the vault owns the data
  assign conceal_mask = {`AES_BLOCK_W{~intercept_i}};
  assign data_out_o   = core_status_i.data_out & conceal_mask;

  // Hardware acknowledges each block itself during capture
  assign data_out_re_o = intercept_i ? output_valid_q : sw_data_out_re_i;

endmodule

//--- design/aes_edn_pkg.sv
////////////////////
// Types for the shared entropy port
// Entropy runs on the same clock as the wrapper
////////////////////

`include "aes_kv_macros.svh"

package aes_edn_pkg;

  // Entropy response, ack qualifies bus for one cycle
  typedef struct packed {
    logic                  ack;
    logic [`AES_EDN_W-1:0] bus;
  } edn_rsp_t;

  // Requester currently served by the arbiter
  // Clearing PRNG wins over masking PRNG
  typedef enum logic [1:0] {
    GrantNone     = 2'd0,
    GrantClearing = 2'd1,
    GrantMasking  = 2'd2
  } edn_grant_e;

endpackage

//--- design/aes_kv_pkg.sv
////////////////////
// Types shared by the AES output data path and key-vault capture
// Word 0 of a block sits in the low bits
// Vault chunk i sits at bit i*AES_BLOCK_W upward
////////////////////

`include "aes_kv_macros.svh"

package aes_kv_pkg;

  ////////////////////
  // Data types
  ////////////////////

  // One output block, word 0 in the low bits
  typedef logic [`AES_DATA_WORDS-1:0][`AES_WORD_W-1:0] aes_block_t;

  // Status updates from the AES core
  typedef struct packed {
    logic       idle_we;
    logic       idle;
    logic       ov_we;
    logic       output_valid;
    aes_block_t data_out;
  } core_status_t;

  // Key-vault output, valid level and the full write buffer
  typedef struct packed {
    logic                     valid;
    logic [`AES_KV_WR_DW-1:0] data;
  } kv_out_t;

  ////////////////////
  // Capture FSM
  ////////////////////

  // Idle waits for arming, Capture collects blocks,
  // Valid holds the buffer until the vault write is done
  typedef enum logic [1:0] {
    KvIdle    = 2'd0,
    KvCapture = 2'd1,
    KvValid   = 2'd2
  } kv_state_e;

endpackage

//--- design/aes_kv_macros.svh
////////////////////
// Width constants for the AES key-vault wrapper
// Block width must equal word width times words per block
// Vault write width must equal block width times chunks per write
////////////////////

`ifndef AES_KV_MACROS_SVH
`define AES_KV_MACROS_SVH

// Core data path
`define AES_WORD_W      32
`define AES_DATA_WORDS  4
`define AES_BLOCK_W     128

// Key-vault write buffer
`define AES_KV_WR_DW    512
`define AES_KV_CHUNKS   4
// Counter must index every chunk
`define AES_KV_CNT_W    2

// Entropy bus
`define AES_EDN_W       32

`endif
